// File: src.f
verilog/rvPkg.sv
verilog/decodeCtrl.sv
verilog/regFile.sv
verilog/immGen.sv
verilog/wbSelect.sv
verilog/pipeReg.sv
verilog/idStage.sv
tb/tbIdStage.sv

// File: Makefile
# Verilator build and run of the ID stage testbench

BIN := obj_dir/VtbIdStage

.PHONY: run clean

run: $(BIN)
	$(BIN) | tee sim.log
	! grep -q "Simulation finished: FAIL" sim.log
	grep -q "Simulation finished: PASS" sim.log

# Rebuilt only when a source or the file list changes
$(BIN): src.f $(shell cat src.f)
	verilator --binary --timing --timescale 1ns/1ns -f src.f --top-module tbIdStage -o VtbIdStage

clean:
	rm -rf obj_dir sim.log

// File: tb/tbIdStage.sv
`timescale 1ns/1ns
`default_nettype none

module tbIdStage;

    localparam int ClkPeriod = 40;
    localparam int ResetCycles = 16;
    localparam int TestCycles = 400;
    localparam int WatchdogNs = (ResetCycles + TestCycles + 50) * ClkPeriod;
    // addi x0, x0, 0
    localparam logic [31:0] NopInst = 32'h0000_0013;

    logic clk, rstN, stall, flush, wbRegWrite;
    logic [31:0] inst, pc, aluResult, memData, wbPc4;
    logic [4:0] wbRd;
    logic [2:0] wbFunct3;
    rvPkg::wbSrcT wbSrc;
    logic [31:0] exRdata1, exRdata2, exImm, exPc;
    logic [4:0] exRs1, exRs2, exRd;
    logic [2:0] exFunct3;
    logic [6:0] exFunct7;
    logic exRegWrite, exMemRead, exMemWrite, exBranch, exJump, exAluSrcImm, exIllegal;
    rvPkg::wbSrcT exWbSrc;

    // Model register file and LCG state
    logic [31:0] model [rvPkg::RegCount];
    logic [31:0] seed = 32'h81e6_9333;
    // Writeback staged for the next drive
    logic sWr;
    logic [4:0] sRd;
    rvPkg::wbSrcT sSrc;
    logic [2:0] sF3;
    logic [31:0] sAlu, sMem, sPc4;
    // Held, pending and compared expectations
    rvPkg::ctrlT hCtrl, pCtrl, cCtrl;
    rvPkg::idDataT hData, pData, cData;
    logic hChk, pChk, cChk, pValid, cValid;
    int errorCount = 0;
    int errBase = 0;
    int passCount = 0;
    int testCount = 0;

    idStage i_idStage (.clk(clk), .rstN(rstN), .inst(inst), .pc(pc), .stall(stall),
        .flush(flush), .wbRegWrite(wbRegWrite), .wbRd(wbRd), .wbSrc(wbSrc),
        .wbFunct3(wbFunct3), .aluResult(aluResult), .memData(memData), .wbPc4(wbPc4),
        .exRdata1(exRdata1), .exRdata2(exRdata2), .exImm(exImm), .exPc(exPc),
        .exRs1(exRs1), .exRs2(exRs2), .exRd(exRd), .exFunct3(exFunct3),
        .exFunct7(exFunct7), .exRegWrite(exRegWrite), .exMemRead(exMemRead),
        .exMemWrite(exMemWrite), .exWbSrc(exWbSrc), .exBranch(exBranch), .exJump(exJump),
        .exAluSrcImm(exAluSrcImm), .exIllegal(exIllegal));

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    // ------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------
    function automatic logic [31:0] nextRand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic rvPkg::ctrlT refCtrl(input logic [31:0] i);
        rvPkg::ctrlT c;
        logic bad;
        c = '0;
        bad = 1'b0;
        case (i[6:0])
            rvPkg::OpLoad: begin
                c.regWrite = 1'b1;
                c.memRead = 1'b1;
                c.wbSrc = rvPkg::WbMem;
                c.aluSrcImm = 1'b1;
                // Only five load widths exist
                bad = (i[14:12] == 3'b011) || (i[14:12] >= 3'b110);
            end
            rvPkg::OpStore: begin
                c.memWrite = 1'b1;
                c.aluSrcImm = 1'b1;
            end
            rvPkg::OpJal, rvPkg::OpJalr: begin
                c.jump = 1'b1;
                c.regWrite = 1'b1;
                c.wbSrc = rvPkg::WbLink;
            end
            rvPkg::OpBranch: c.branch = 1'b1;
            rvPkg::OpImm, rvPkg::OpLui, rvPkg::OpAuipc: begin
                c.regWrite = 1'b1;
                c.aluSrcImm = 1'b1;
            end
            rvPkg::OpReg: begin
                c.regWrite = 1'b1;
                bad = (i[31:25] != 7'h00) && (i[31:25] != 7'h20);
            end
            default: bad = 1'b1;
        endcase
        if (bad) begin
            c = '0;
            c.illegal = 1'b1;
        end
        return c;
    endfunction

    function automatic logic [31:0] refImm(input logic [31:0] i);
        rvPkg::ctrlT c;
        c = refCtrl(i);
        // Illegal words carry no immediate
        if (c.illegal) return 32'd0;
        case (i[6:0])
            rvPkg::OpLoad, rvPkg::OpImm, rvPkg::OpJalr: return 32'($signed(i[31:20]));
            rvPkg::OpStore: return 32'($signed({i[31:25], i[11:7]}));
            rvPkg::OpBranch: return 32'($signed({i[31], i[7], i[30:25], i[11:8], 1'b0}));
            rvPkg::OpLui, rvPkg::OpAuipc: return {i[31:12], 12'h000};
            rvPkg::OpJal: return 32'($signed({i[31], i[19:12], i[20], i[30:21], 1'b0}));
            default: return 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] refWbData(input rvPkg::wbSrcT src, input logic [2:0] f3,
                                              input logic [31:0] alu, mem, pc4);
        case (src)
            rvPkg::WbAlu: return alu;
            rvPkg::WbLink: return pc4;
            rvPkg::WbMem: begin
                case (f3)
                    rvPkg::F3Lb: return 32'($signed(mem[7:0]));
                    rvPkg::F3Lh: return 32'($signed(mem[15:0]));
                    rvPkg::F3Lw: return mem;
                    rvPkg::F3Lbu: return 32'(mem[7:0]);
                    rvPkg::F3Lhu: return 32'(mem[15:0]);
                    default: return 32'd0;
                endcase
            end
            default: return 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] readModel(input logic [4:0] a);
        return (a == 5'd0) ? 32'd0 : model[a];
    endfunction

    // ------------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------------
    function automatic logic [31:0] rType(input logic [4:0] rs1, rs2, rd);
        return {7'h00, rs2, rs1, 3'b000, rd, rvPkg::OpReg};
    endfunction

    function automatic logic [31:0] randPc();
        logic [31:0] r;
        r = nextRand();
        return {r[31:2], 2'b00};
    endfunction

    // Mix of all opcodes plus illegal words
    function automatic logic [31:0] randInst();
        logic [31:0] r;
        logic [31:0] sel;
        r = nextRand();
        sel = nextRand() % 32'd12;
        case (sel)
            0: return {r[31:7], rvPkg::OpLui};
            1: return {r[31:7], rvPkg::OpAuipc};
            2: return {r[31:7], rvPkg::OpJal};
            3: return {r[31:7], rvPkg::OpJalr};
            4: return {r[31:7], rvPkg::OpBranch};
            5: return {r[31:7], rvPkg::OpLoad};
            6: return {r[31:7], rvPkg::OpStore};
            7: return {r[31:7], rvPkg::OpImm};
            8: return {r[31] ? 7'h20 : 7'h00, r[24:7], rvPkg::OpReg};
            10: return {r[31:7], rvPkg::OpReg};
            11: return {r[31:15], 3'b011, r[11:7], rvPkg::OpLoad};
            default: return r;
        endcase
    endfunction

    task automatic setWb(input logic wr, input logic [4:0] rd, input rvPkg::wbSrcT src,
                         input logic [2:0] f3, input logic [31:0] alu, mem, pc4);
        sWr = wr;
        sRd = rd;
        sSrc = src;
        sF3 = f3;
        sAlu = alu;
        sMem = mem;
        sPc4 = pc4;
    endtask

    // One decode cycle and its expectation for the compare process
    task automatic driveCycle(input logic [31:0] instW, pcW, input logic st, fl);
        rvPkg::ctrlT c;
        rvPkg::idDataT d;
        @(posedge clk);
        #2;
        inst = instW;
        pc = pcW;
        stall = st;
        flush = fl;
        wbRegWrite = sWr;
        wbRd = sRd;
        wbSrc = sSrc;
        wbFunct3 = sF3;
        aluResult = sAlu;
        memData = sMem;
        wbPc4 = sPc4;
        // Model write first so that reads below see the bypass
        if (sWr && sRd != 5'd0) model[sRd] = refWbData(sSrc, sF3, sAlu, sMem, sPc4);
        sWr = 1'b0;
        if (!st) begin
            c = refCtrl(instW);
            d.rdata1 = readModel(instW[19:15]);
            d.rdata2 = readModel(instW[24:20]);
            d.imm = refImm(instW);
            d.pc = pcW;
            d.rs1 = instW[19:15];
            d.rs2 = instW[24:20];
            d.rd = instW[11:7];
            d.funct3 = instW[14:12];
            d.funct7 = instW[31:25];
            hChk = 1'b1;
            // A bubble leaves the data unchecked
            if (fl) begin
                c = '0;
                hChk = 1'b0;
            end
            hCtrl = c;
            hData = d;
        end
        pCtrl = hCtrl;
        pData = hData;
        pChk = hChk;
        pValid = 1'b1;
    endtask

    task automatic endTest(input string name);
        int errs;
        driveCycle(NopInst, 32'd0, 1'b0, 1'b1);
        repeat (2) @(posedge clk);
        errs = errorCount - errBase;
        testCount++;
        errBase = errorCount;
        if (errs == 0) begin
            passCount++;
            $display("Test %s: passed", name);
        end else begin
            $display("Test %s: failed with %0d errors", name, errs);
        end
    endtask

    // ------------------------------------------------------------------
    // Comparison
    // ------------------------------------------------------------------
    function automatic logic [8:0] ctrlOut();
        return {exRegWrite, exMemRead, exMemWrite, exWbSrc, exBranch, exJump, exAluSrcImm,
                exIllegal};
    endfunction

    task automatic checkWord(input string name, input logic [31:0] got, exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, name, got, exp);
            errorCount++;
        end
    endtask

    // Picks up at the edge that registers the drive and compares mid-cycle
    initial begin
        forever begin
            @(posedge clk);
            cValid = pValid;
            cCtrl = pCtrl;
            cData = pData;
            cChk = pChk;
            pValid = 1'b0;
            @(negedge clk);
            if (cValid) begin
                checkWord("control", 32'(ctrlOut()), 32'(cCtrl));
                if (cChk) begin
                    checkWord("exRdata1", exRdata1, cData.rdata1);
                    checkWord("exRdata2", exRdata2, cData.rdata2);
                    checkWord("exImm", exImm, cData.imm);
                    checkWord("exPc", exPc, cData.pc);
                    checkWord("exRs1", 32'(exRs1), 32'(cData.rs1));
                    checkWord("exRs2", 32'(exRs2), 32'(cData.rs2));
                    checkWord("exRd", 32'(exRd), 32'(cData.rd));
                    checkWord("exFunct3", 32'(exFunct3), 32'(cData.funct3));
                    checkWord("exFunct7", 32'(exFunct7), 32'(cData.funct7));
                end
            end
        end
    end

    initial begin
        #(WatchdogNs);
        $display("Timeout: the tests did not finish within %0d ns", WatchdogNs);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // ------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------
    initial begin
        logic [31:0] a;
        logic [31:0] r;
        logic [4:0] rd;
        rstN = 1'b0;
        inst = NopInst;
        pc = 32'd0;
        stall = 1'b0;
        flush = 1'b1;
        setWb(1'b0, 5'd0, rvPkg::WbAlu, 3'd0, 32'd0, 32'd0, 32'd0);
        wbRegWrite = 1'b0;
        wbRd = 5'd0;
        wbSrc = rvPkg::WbAlu;
        wbFunct3 = 3'd0;
        aluResult = 32'd0;
        memData = 32'd0;
        wbPc4 = 32'd0;
        hCtrl = '0;
        hData = '0;
        hChk = 1'b0;
        pValid = 1'b0;
        for (int i = 0; i < rvPkg::RegCount; i++) model[i] = 32'd0;

        // Reset state and then a read of every register
        repeat (ResetCycles) begin
            @(negedge clk);
            checkWord("control in reset", 32'(ctrlOut()), 32'd0);
            checkWord("exRdata1 in reset", exRdata1, 32'd0);
            checkWord("exPc in reset", exPc, 32'd0);
        end
        @(posedge clk);
        #2;
        rstN = 1'b1;
        driveCycle(NopInst, 32'd0, 1'b0, 1'b1);
        for (int i = 0; i < 32; i++) begin
            driveCycle(rType(5'(i), 5'(31 - i), 5'd0), randPc(), 1'b0, 1'b0);
        end
        endTest("reset state");

        // ALU writeback including x0
        for (int k = 0; k < 40; k++) begin
            r = nextRand();
            rd = (k % 8 == 0) ? 5'd0 : r[4:0];
            setWb(1'b1, rd, rvPkg::WbAlu, 3'd0, nextRand(), nextRand(), nextRand());
            driveCycle(NopInst, randPc(), 1'b0, 1'b0);
            r = nextRand();
            driveCycle(rType(rd, r[9:5], 5'd1), randPc(), 1'b0, 1'b0);
        end
        endTest("ALU writeback");

        // Every funct3 code with bit 7 and bit 15 patterns
        for (int f = 0; f < 8; f++) begin
            for (int p = 0; p < 2; p++) begin
                rd = 5'(f * 2 + p + 1);
                setWb(1'b1, rd, rvPkg::WbMem, 3'(f), nextRand(),
                      (p == 0) ? 32'h0001_7f80 : 32'h0000_8055, 32'd0);
                driveCycle(NopInst, randPc(), 1'b0, 1'b0);
                driveCycle(rType(rd, 5'd0, 5'd2), randPc(), 1'b0, 1'b0);
            end
        end
        setWb(1'b1, 5'd20, rvPkg::WbLink, rvPkg::F3Lw, nextRand(), nextRand(), 32'h0000_1004);
        driveCycle(NopInst, randPc(), 1'b0, 1'b0);
        driveCycle(rType(5'd0, 5'd20, 5'd2), randPc(), 1'b0, 1'b0);
        endTest("load extension and link");

        // Write and read of the same register in one cycle
        setWb(1'b1, 5'd7, rvPkg::WbAlu, 3'd0, 32'hcafe_0007, 32'd0, 32'd0);
        driveCycle(rType(5'd7, 5'd7, 5'd3), randPc(), 1'b0, 1'b0);
        setWb(1'b1, 5'd8, rvPkg::WbLink, 3'd0, 32'd0, 32'd0, 32'h0000_2468);
        driveCycle(rType(5'd8, 5'd7, 5'd3), randPc(), 1'b0, 1'b0);
        setWb(1'b1, 5'd0, rvPkg::WbAlu, 3'd0, 32'hffff_ffff, 32'd0, 32'd0);
        driveCycle(rType(5'd0, 5'd0, 5'd3), randPc(), 1'b0, 1'b0);
        endTest("write-read bypass");

        for (int k = 0; k < 200; k++) driveCycle(randInst(), randPc(), 1'b0, 1'b0);
        endTest("random decode");

        // Live load held by stall and by stall with flush, then flushed and held as a bubble
        a = {12'h004, 5'd3, 3'b010, 5'd9, rvPkg::OpLoad};
        driveCycle(a, 32'h0000_0100, 1'b0, 1'b0);
        driveCycle(randInst(), randPc(), 1'b1, 1'b0);
        driveCycle(randInst(), randPc(), 1'b1, 1'b1);
        driveCycle(a, 32'h0000_0104, 1'b0, 1'b1);
        driveCycle(randInst(), randPc(), 1'b1, 1'b1);
        driveCycle(a, 32'h0000_0108, 1'b0, 1'b0);
        endTest("stall and flush");

        $display("Summary: %0d of %0d tests passed, %0d errors", passCount, testCount,
                 errorCount);
        if (errorCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/idStage.sv
`timescale 1ns/1ns
`default_nettype none

module idStage (
    input  wire               clk,
    input  wire               rstN,
    input  wire [31:0]        inst,
    input  wire [31:0]        pc,
    input  wire               stall,
    input  wire               flush,
    input  wire               wbRegWrite,
    input  wire [4:0]         wbRd,
    input  wire rvPkg::wbSrcT wbSrc,
    input  wire [2:0]         wbFunct3,
    input  wire [31:0]        aluResult,
    input  wire [31:0]        memData,
    input  wire [31:0]        wbPc4,
    output logic [31:0]       exRdata1,
    output logic [31:0]       exRdata2,
    output logic [31:0]       exImm,
    output logic [31:0]       exPc,
    output logic [4:0]        exRs1,
    output logic [4:0]        exRs2,
    output logic [4:0]        exRd,
    output logic [2:0]        exFunct3,
    output logic [6:0]        exFunct7,
    output logic              exRegWrite,
    output logic              exMemRead,
    output logic              exMemWrite,
    output rvPkg::wbSrcT      exWbSrc,
    output logic              exBranch,
    output logic              exJump,
    output logic              exAluSrcImm,
    output logic              exIllegal
);

    rvPkg::ctrlT    ctrl, exCtrl;
    rvPkg::idDataT  idData, exData;
    rvPkg::immTypeT immType;
    logic [31:0]    imm, rdata1, rdata2, wbData;

    // ------------------------------------------------------------------
    // Decode side
    // ------------------------------------------------------------------
    decodeCtrl i_decodeCtrl (.opcode(inst[6:0]), .funct3(inst[14:12]),
        .funct7(inst[31:25]), .ctrl(ctrl), .immType(immType));

    immGen i_immGen (.inst(inst), .immType(immType), .imm(imm));

    // Writeback data into the register file
    wbSelect i_wbSelect (.wbSrc(wbSrc), .funct3(wbFunct3), .aluResult(aluResult),
        .memData(memData), .pc4(wbPc4), .wbData(wbData));

    regFile i_regFile (.clk(clk), .rstN(rstN), .raddr1(inst[19:15]), .raddr2(inst[24:20]),
        .waddr(wbRd), .wdata(wbData), .regWrite(wbRegWrite), .rdata1(rdata1),
        .rdata2(rdata2));

    // Field split straight from the instruction word
    assign idData = '{rdata1: rdata1, rdata2: rdata2, imm: imm, pc: pc, rs1: inst[19:15],
                      rs2: inst[24:20], rd: inst[11:7], funct3: inst[14:12],
                      funct7: inst[31:25]};

    // ------------------------------------------------------------------
    // ID/EX registers
    // ------------------------------------------------------------------
    pipeReg #(.payloadT(rvPkg::ctrlT)) i_ctrlReg (.clk(clk), .rstN(rstN), .stall(stall),
        .flush(flush), .d(ctrl), .q(exCtrl));

    // Data rides through a flush, the bubble lives in control only
    pipeReg #(.payloadT(rvPkg::idDataT)) i_dataReg (.clk(clk), .rstN(rstN), .stall(stall),
        .flush(1'b0), .d(idData), .q(exData));

    // Unpack onto the execute-side ports
    assign exRdata1    = exData.rdata1;
    assign exRdata2    = exData.rdata2;
    assign exImm       = exData.imm;
    assign exPc        = exData.pc;
    assign exRs1       = exData.rs1;
    assign exRs2       = exData.rs2;
    assign exRd        = exData.rd;
    assign exFunct3    = exData.funct3;
    assign exFunct7    = exData.funct7;
    assign exRegWrite  = exCtrl.regWrite;
    assign exMemRead   = exCtrl.memRead;
    assign exMemWrite  = exCtrl.memWrite;
    assign exWbSrc     = exCtrl.wbSrc;
    assign exBranch    = exCtrl.branch;
    assign exJump      = exCtrl.jump;
    assign exAluSrcImm = exCtrl.aluSrcImm;
    assign exIllegal   = exCtrl.illegal;

endmodule

`default_nettype wire

// File: verilog/pipeReg.sv
`timescale 1ns/1ns
`default_nettype none

module pipeReg #(
    parameter type payloadT = logic [31:0]
) (
    input  wire     clk,
    input  wire     rstN,
    input  wire     stall,
    input  wire     flush,
    input  wire     payloadT d,
    output payloadT q
);

    // Stall beats flush, flush inserts zero
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            q <= '0;
        end else if (stall) begin
            // Hold current stage contents
            q <= q;
        end else if (flush) begin
            q <= '0;
        end else begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

// File: verilog/wbSelect.sv
`timescale 1ns/1ns
`default_nettype none

module wbSelect (
    input  wire rvPkg::wbSrcT wbSrc,
    input  wire [2:0]         funct3,
    input  wire [31:0]        aluResult,
    input  wire [31:0]        memData,
    input  wire [31:0]        pc4,
    output logic [31:0]       wbData
);

    // Load data after width and extension
    logic [31:0] loadData;

    // ------------------------------------------------------------------
    // Load extension
    // ------------------------------------------------------------------
    always_comb begin
        case (funct3)
            rvPkg::F3Lb:  loadData = {{24{memData[7]}}, memData[7:0]};
            // Halfword sign is bit 15
            rvPkg::F3Lh:  loadData = {{16{memData[15]}}, memData[15:0]};
            rvPkg::F3Lw:  loadData = memData;
            rvPkg::F3Lbu: loadData = {24'd0, memData[7:0]};
            rvPkg::F3Lhu: loadData = {16'd0, memData[15:0]};
            default:      loadData = 32'd0;
        endcase
    end

    // Source picked by the writeback stage
    always_comb begin
        case (wbSrc)
            rvPkg::WbAlu:  wbData = aluResult;
            rvPkg::WbMem:  wbData = loadData;
            rvPkg::WbLink: wbData = pc4;
            default:       wbData = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/immGen.sv
`timescale 1ns/1ns
`default_nettype none

module immGen (
    input  wire [31:0]          inst,
    input  wire rvPkg::immTypeT immType,
    output logic [31:0]         imm
);

    // Sign always comes from inst[31]
    logic sgn;

    assign sgn = inst[31];

    always_comb begin
        case (immType)
            // Loads, OP-IMM, JALR
            rvPkg::ImmI: imm = {{20{sgn}}, inst[31:20]};
            // Stores, offset split around rd field
            rvPkg::ImmS: imm = {{20{sgn}}, inst[31:25], inst[11:7]};
            // Branches, bit 0 implied zero
            rvPkg::ImmB: begin
                imm = {{19{sgn}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            // LUI and AUIPC, low 12 bits zero
            rvPkg::ImmU: imm = {inst[31:12], 12'd0};
            // JAL, scrambled 20-bit offset
            rvPkg::ImmJ: begin
                imm = {{11{sgn}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: imm = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/regFile.sv
`timescale 1ns/1ns
`default_nettype none

module regFile (
    input  wire        clk,
    input  wire        rstN,
    input  wire [4:0]  raddr1,
    input  wire [4:0]  raddr2,
    input  wire [4:0]  waddr,
    input  wire [31:0] wdata,
    input  wire        regWrite,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2
);

    // x1 to x31, x0 has no storage
    logic [31:0] regs [1:rvPkg::RegCount-1];

    logic wrEn;

    // Writes to x0 are dropped
    assign wrEn = regWrite && (waddr != 5'd0);

    // ------------------------------------------------------------------
    // Write port
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < rvPkg::RegCount; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[waddr] <= wdata;
        end
    end

    // ------------------------------------------------------------------
    // Read ports
    // ------------------------------------------------------------------
    // Zero first, then bypass of the write in flight, then storage
    assign rdata1 = (raddr1 == 5'd0)                 ? 32'd0 :
                    (wrEn && (waddr == raddr1))      ? wdata :
                                                       regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0)                 ? 32'd0 :
                    (wrEn && (waddr == raddr2))      ? wdata :
                                                       regs[raddr2];

endmodule

`default_nettype wire

// File: verilog/decodeCtrl.sv
`timescale 1ns/1ns
`default_nettype none

module decodeCtrl (
    input  wire [6:0]     opcode,
    input  wire [2:0]     funct3,
    input  wire [6:0]     funct7,
    output rvPkg::ctrlT    ctrl,
    output rvPkg::immTypeT immType
);

    // ------------------------------------------------------------------
    // Opcode table
    // ------------------------------------------------------------------
    always_comb begin
        // Start from a bubble
        ctrl    = '0;
        immType = rvPkg::ImmNone;
        case (opcode)
            rvPkg::OpLoad: begin
                ctrl.regWrite  = 1'b1;
                ctrl.memRead   = 1'b1;
                ctrl.wbSrc     = rvPkg::WbMem;
                ctrl.aluSrcImm = 1'b1;
                immType        = rvPkg::ImmI;
            end
            rvPkg::OpStore: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                immType        = rvPkg::ImmS;
            end
            rvPkg::OpJal: begin
                ctrl.jump     = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.wbSrc    = rvPkg::WbLink;
                immType       = rvPkg::ImmJ;
            end
            rvPkg::OpJalr: begin
                ctrl.jump     = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.wbSrc    = rvPkg::WbLink;
                immType       = rvPkg::ImmI;
            end
            rvPkg::OpBranch: begin
                ctrl.branch = 1'b1;
                immType     = rvPkg::ImmB;
            end
            rvPkg::OpImm: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                immType        = rvPkg::ImmI;
            end
            rvPkg::OpLui, rvPkg::OpAuipc: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                immType        = rvPkg::ImmU;
            end
            rvPkg::OpReg: begin
                ctrl.regWrite = 1'b1;
            end
            default: begin
                // Unknown opcode
                ctrl.illegal = 1'b1;
            end
        endcase

        // Bad load width
        if (opcode == rvPkg::OpLoad && funct3 != rvPkg::F3Lb && funct3 != rvPkg::F3Lh
            && funct3 != rvPkg::F3Lw && funct3 != rvPkg::F3Lbu && funct3 != rvPkg::F3Lhu) begin
            ctrl.illegal = 1'b1;
        end
        // Only base and alternate funct7 exist for OP
        if (opcode == rvPkg::OpReg && funct7 != 7'h00 && funct7 != 7'h20) begin
            ctrl.illegal = 1'b1;
        end

        // Illegal leaves nothing else active, no immediate either
        if (ctrl.illegal) begin
            ctrl         = '0;
            ctrl.illegal = 1'b1;
            immType      = rvPkg::ImmNone;
        end
    end

endmodule

`default_nettype wire

// File: verilog/rvPkg.sv
`default_nettype none

package rvPkg;

    // ------------------------------------------------------------------
    // Base opcodes, inst[6:0]
    // ------------------------------------------------------------------
    localparam logic [6:0] OpLui    = 7'b0110111;
    localparam logic [6:0] OpAuipc  = 7'b0010111;
    localparam logic [6:0] OpJal    = 7'b1101111;
    localparam logic [6:0] OpJalr   = 7'b1100111;
    localparam logic [6:0] OpBranch = 7'b1100011;
    localparam logic [6:0] OpLoad   = 7'b0000011;
    localparam logic [6:0] OpStore  = 7'b0100011;
    localparam logic [6:0] OpImm    = 7'b0010011;
    localparam logic [6:0] OpReg    = 7'b0110011;

    // Load widths in funct3
    localparam logic [2:0] F3Lb  = 3'b000;
    localparam logic [2:0] F3Lh  = 3'b001;
    localparam logic [2:0] F3Lw  = 3'b010;
    localparam logic [2:0] F3Lbu = 3'b100;
    localparam logic [2:0] F3Lhu = 3'b101;

    // Architectural registers, x0 included
    localparam int RegCount = 32;

    // ------------------------------------------------------------------
    // Decode enums
    // ------------------------------------------------------------------
    // Immediate format picked by the decoder
    typedef enum logic [2:0] {
        ImmNone,
        ImmI,
        ImmS,
        ImmB,
        ImmU,
        ImmJ
    } immTypeT;

    // Writeback data source
    typedef enum logic [1:0] {
        WbAlu,
        WbMem,
        WbLink
    } wbSrcT;

    // ------------------------------------------------------------------
    // ID/EX payloads
    // ------------------------------------------------------------------
    // Control bundle, all zero is a bubble
    typedef struct packed {
        logic  regWrite;
        logic  memRead;
        logic  memWrite;
        wbSrcT wbSrc;
        logic  branch;
        logic  jump;
        logic  aluSrcImm;
        logic  illegal;
    } ctrlT;

    // Operands and fields handed to execute
    typedef struct packed {
        logic [31:0] rdata1;
        logic [31:0] rdata2;
        logic [31:0] imm;
        logic [31:0] pc;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [2:0]  funct3;
        logic [6:0]  funct7;
    } idDataT;

endpackage

`default_nettype wire
